// ==== rtl/ice51_pkg.sv ====
package ice51_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths

   localparam int CODE_AW = 10;   // code address, 1k bytes
   localparam int BYTE_W  = 8;

   //////////////////////////////////////////////////////////////////////
   // opcodes, 8051 encodings

   localparam logic [BYTE_W-1:0] OP_LJMP   = 8'h02;   // ljmp addr16
   localparam logic [BYTE_W-1:0] OP_INCA   = 8'h04;   // inc a
   localparam logic [BYTE_W-1:0] OP_DECA   = 8'h14;   // dec a
   localparam logic [BYTE_W-1:0] OP_ADDAI  = 8'h24;   // add a,#imm
   localparam logic [BYTE_W-1:0] OP_JZ     = 8'h60;   // jz rel
   localparam logic [BYTE_W-1:0] OP_JNZ    = 8'h70;   // jnz rel
   localparam logic [BYTE_W-1:0] OP_MOVAI  = 8'h74;   // mov a,#imm
   localparam logic [BYTE_W-1:0] OP_SJMP   = 8'h80;   // sjmp rel
   localparam logic [BYTE_W-1:0] OP_MOVDP  = 8'h90;   // mov dptr,#imm16
   localparam logic [BYTE_W-1:0] OP_MOVXAD = 8'hE0;   // movx a,@dptr
   localparam logic [BYTE_W-1:0] OP_MOVXDA = 8'hF0;   // movx @dptr,a

   //////////////////////////////////////////////////////////////////////
   // memory-mapped uart registers

   localparam logic [2*BYTE_W-1:0] MMIO_TX_STATUS = 16'h0200;   // bit 0 = tx busy
   localparam logic [2*BYTE_W-1:0] MMIO_TX_DATA   = 16'h0201;   // write starts a frame

   // data pointer, compared as one address, loaded per byte
   typedef union packed {
      logic [2*BYTE_W-1:0]      word;
      logic [1:0][BYTE_W-1:0]   bytes;   // [1] dph, [0] dpl
   } dptr_t;

endpackage

// ==== rtl/cpu_step_if.sv ====
interface cpu_step_if;
   import ice51_pkg::*;

   logic                exec_stb;     // one cycle per instruction
   logic [BYTE_W-1:0]   opcode;
   logic [BYTE_W-1:0]   operand_hi;   // first operand of three-byte ops
   logic [BYTE_W-1:0]   operand_lo;   // immediate, offset or low address byte
   logic                acc_zero;

   modport seq (
      output exec_stb, opcode, operand_hi, operand_lo,
      input  acc_zero
   );

   modport exe (
      input  exec_stb, opcode, operand_hi, operand_lo,
      output acc_zero
   );

endinterface

// ==== rtl/uart_rx.sv ====
module uart_rx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_rx,
   output logic                          o_byte_stb,
   output logic [ice51_pkg::BYTE_W-1:0]  o_byte
);
   import ice51_pkg::*;

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] FULL     = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF     = CW'(CLKS_PER_BIT / 2 - 1);
   localparam logic [3:0]    STOP_IDX = 4'(BYTE_W + 1);

   logic            rx_meta, rx_sync;
   logic            active;
   logic [CW-1:0]   cnt;
   logic [3:0]      bit_idx;   // 0 start, 1..8 data, 9 stop
   logic            sample;

   // two-flop resync, line idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   // start bit waits half a period, every later bit a full one
   assign sample = active & (cnt == ((bit_idx == 4'd0) ? HALF : FULL));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         active     <= 1'b0;
         cnt        <= '0;
         bit_idx    <= '0;
         o_byte_stb <= 1'b0;
      end else begin
         o_byte_stb <= 1'b0;
         if (!active) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (!rx_sync) active <= 1'b1;   // line high before, so this is the edge
         end else if (sample) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd0 && rx_sync) active <= 1'b0;   // glitch, no start bit
            if (bit_idx == STOP_IDX) begin
               active     <= 1'b0;
               o_byte_stb <= rx_sync;   // drop frames with a bad stop bit
            end
         end else begin
            cnt <= cnt + CW'(1);
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge i_clk) begin
      if (sample && bit_idx != 4'd0 && bit_idx != STOP_IDX) begin
         o_byte <= {rx_sync, o_byte[BYTE_W-1:1]};
      end
   end

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_stb,
   input  logic [ice51_pkg::BYTE_W-1:0]  i_byte,
   output logic                          o_busy,
   output logic                          o_tx
);
   import ice51_pkg::*;

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] FULL     = CW'(CLKS_PER_BIT - 1);
   localparam logic [3:0]    LAST_BIT = 4'(BYTE_W + 1);   // stop bit

   logic [BYTE_W+1:0]   shreg;   // stop, data, start
   logic [CW-1:0]       cnt;
   logic [3:0]          bit_idx;
   logic                bit_end;

   assign bit_end = o_busy & (cnt == FULL);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_busy  <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (!o_busy) begin
         cnt     <= '0;
         bit_idx <= '0;
         if (i_stb) o_busy <= 1'b1;
      end else if (bit_end) begin
         cnt     <= '0;
         bit_idx <= bit_idx + 4'd1;
         if (bit_idx == LAST_BIT) o_busy <= 1'b0;   // whole frame sent
      end else begin
         cnt <= cnt + CW'(1);
      end
   end

   // strobes during a frame are lost, idle shifter holds all ones
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         shreg <= '1;
      end else if (!o_busy && i_stb) begin
         shreg <= {1'b1, i_byte, 1'b0};
      end else if (bit_end) begin
         shreg <= {1'b1, shreg[BYTE_W+1:1]};   // lsb first
      end
   end

   assign o_tx = shreg[0];   // ones fill in behind the stop bit

endmodule

// ==== rtl/program_loader.sv ====
module program_loader #(
   parameter int LOAD_BYTES = 512
) (
   input  logic                           i_clk,
   input  logic                           i_nrst,
   input  logic                           i_byte_stb,
   input  logic [ice51_pkg::BYTE_W-1:0]   i_byte,
   input  logic [ice51_pkg::CODE_AW-1:0]  i_fetch_addr,
   output logic                           o_load_done,
   output logic                           o_code_wr,
   output logic [ice51_pkg::CODE_AW-1:0]  o_code_addr,
   output logic [ice51_pkg::BYTE_W-1:0]   o_code_data
);
   import ice51_pkg::*;

   localparam logic [CODE_AW-1:0] LAST = CODE_AW'(LOAD_BYTES - 1);

   logic [CODE_AW-1:0] count;   // next write address

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count       <= '0;
         o_load_done <= 1'b0;
      end else if (o_code_wr) begin
         count <= count + CODE_AW'(1);
         if (count == LAST) o_load_done <= 1'b1;   // sticky until reset
      end
   end

   assign o_code_wr   = i_byte_stb & ~o_load_done;
   assign o_code_data = i_byte;
   assign o_code_addr = o_load_done ? i_fetch_addr : count;   // cpu owns memory once loaded

endmodule

// ==== rtl/cpu_sequencer.sv ====
module cpu_sequencer (
   input  logic                           i_clk,
   input  logic                           i_nrst,
   input  logic                           i_load_done,
   input  logic [ice51_pkg::BYTE_W-1:0]   i_code_data,
   output logic [ice51_pkg::CODE_AW-1:0]  o_fetch_addr,
   cpu_step_if.seq                        step
);
   import ice51_pkg::*;

   localparam logic [2:0] S_FETCH   = 3'd0;
   localparam logic [2:0] S_DECODE0 = 3'd1;
   localparam logic [2:0] S_DECODE1 = 3'd2;
   localparam logic [2:0] S_DECODE2 = 3'd3;
   localparam logic [2:0] S_EXECUTE = 3'd4;

   logic [2:0]            state, state_nxt;
   logic [CODE_AW-1:0]    pc, rel_target;
   logic [BYTE_W-1:0]     opcode_q, hi_q, lo_q;
   logic [2*BYTE_W-1:0]   abs_addr;
   logic [1:0]            ops_now;
   logic                  pc_inc, take_rel, take_abs;

   // operand bytes after the opcode, unknown ops are one-byte no-ops
   function automatic logic [1:0] op_len(input logic [BYTE_W-1:0] op);
      case (op)
         OP_MOVAI, OP_ADDAI, OP_SJMP, OP_JZ, OP_JNZ: op_len = 2'd1;
         OP_MOVDP, OP_LJMP:                          op_len = 2'd2;
         default:                                    op_len = 2'd0;
      endcase
   endfunction

   // opcode is on the code bus during decode0, latched after
   assign ops_now = op_len((state == S_DECODE0) ? i_code_data : opcode_q);

   //////////////////////////////////////////////////////////////////////
   // state machine

   always_comb begin
      state_nxt = state;
      case (state)
         S_FETCH:   if (i_load_done) state_nxt = S_DECODE0;
         S_DECODE0: state_nxt = (ops_now == 2'd0) ? S_EXECUTE : S_DECODE1;
         S_DECODE1: state_nxt = (ops_now == 2'd2) ? S_DECODE2 : S_EXECUTE;
         S_DECODE2: state_nxt = S_EXECUTE;
         default:   state_nxt = S_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= S_FETCH;
      else         state <= state_nxt;
   end

   // read data lags the address by one cycle, so latch one state late
   always_ff @(posedge i_clk) begin
      if (state == S_DECODE0) opcode_q <= i_code_data;
      if (state == S_DECODE1) begin
         if (ops_now == 2'd2) hi_q <= i_code_data;
         else                 lo_q <= i_code_data;   // two-byte ops keep it low
      end
      if (state == S_DECODE2) lo_q <= i_code_data;
   end

   //////////////////////////////////////////////////////////////////////
   // program counter

   // pc points past the last byte read, so it is the next instruction in execute
   assign pc_inc = ((state == S_FETCH) & i_load_done) |
                   ((state == S_DECODE0) & (ops_now != 2'd0)) |
                   ((state == S_DECODE1) & (ops_now == 2'd2));

   assign abs_addr   = {hi_q, lo_q};
   assign rel_target = pc + {{(CODE_AW-BYTE_W){lo_q[BYTE_W-1]}}, lo_q};   // wraps
   assign take_abs   = (opcode_q == OP_LJMP);
   assign take_rel   = (opcode_q == OP_SJMP) |
                       ((opcode_q == OP_JZ) & step.acc_zero) |
                       ((opcode_q == OP_JNZ) & ~step.acc_zero);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         pc <= '0;
      end else if (state == S_EXECUTE) begin
         if (take_abs)      pc <= abs_addr[CODE_AW-1:0];
         else if (take_rel) pc <= rel_target;
      end else if (pc_inc) begin
         pc <= pc + CODE_AW'(1);
      end
   end

   assign o_fetch_addr    = pc;
   assign step.exec_stb   = (state == S_EXECUTE);
   assign step.opcode     = opcode_q;
   assign step.operand_hi = hi_q;
   assign step.operand_lo = lo_q;

endmodule

// ==== rtl/cpu_execute.sv ====
module cpu_execute (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   cpu_step_if.exe                       step,
   input  logic                          i_tx_busy,
   output logic                          o_tx_stb,
   output logic [ice51_pkg::BYTE_W-1:0]  o_tx_byte
);
   import ice51_pkg::*;

   logic [BYTE_W-1:0]   acc;
   dptr_t               dptr;
   logic                at_tx_data, at_tx_status;

   // mmio decode
   assign at_tx_data   = (dptr.word == MMIO_TX_DATA);
   assign at_tx_status = (dptr.word == MMIO_TX_STATUS);

   //////////////////////////////////////////////////////////////////////
   // accumulator and data pointer

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc       <= '0;
         dptr.word <= '0;
      end else if (step.exec_stb) begin
         case (step.opcode)
            OP_MOVAI:  acc <= step.operand_lo;
            OP_ADDAI:  acc <= acc + step.operand_lo;   // no carry kept
            OP_INCA:   acc <= acc + BYTE_W'(1);
            OP_DECA:   acc <= acc - BYTE_W'(1);
            OP_MOVXAD: begin
               // only the status register is readable, the rest reads zero
               acc <= at_tx_status ? {{(BYTE_W-1){1'b0}}, i_tx_busy} : '0;
            end
            OP_MOVDP: begin
               dptr.bytes[1] <= step.operand_hi;
               dptr.bytes[0] <= step.operand_lo;
            end
            default: ;
         endcase
      end
   end

   assign step.acc_zero = (acc == '0);

   // a write to the data register starts a frame, lost if the uart is busy
   assign o_tx_stb  = step.exec_stb & (step.opcode == OP_MOVXDA) & at_tx_data;
   assign o_tx_byte = acc;

endmodule

// ==== rtl/ice51_top.sv ====
module ice51_top #(
   parameter int CLKS_PER_BIT = 104,
   parameter int LOAD_BYTES   = 512
) (
   input  logic                           i_clk,
   input  logic                           i_nrst,
   input  logic                           i_uart_rx,
   output logic                           o_uart_tx,
   output logic                           o_code_wr,
   output logic [ice51_pkg::CODE_AW-1:0]  o_code_addr,
   output logic [ice51_pkg::BYTE_W-1:0]   o_code_data,
   input  logic [ice51_pkg::BYTE_W-1:0]   i_code_data
);
   import ice51_pkg::*;

   logic                 rx_stb;
   logic [BYTE_W-1:0]    rx_byte;
   logic                 load_done;
   logic [CODE_AW-1:0]   fetch_addr;
   logic                 tx_stb, tx_busy;
   logic [BYTE_W-1:0]    tx_byte;

   cpu_step_if step_bus ();

   //////////////////////////////////////////////////////////////////////
   // boot path

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_rx       (i_uart_rx),
      .o_byte_stb (rx_stb),
      .o_byte     (rx_byte)
   );

   program_loader #(.LOAD_BYTES(LOAD_BYTES)) program_loader_inst (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_byte_stb   (rx_stb),
      .i_byte       (rx_byte),
      .i_fetch_addr (fetch_addr),
      .o_load_done  (load_done),
      .o_code_wr    (o_code_wr),
      .o_code_addr  (o_code_addr),
      .o_code_data  (o_code_data)
   );

   //////////////////////////////////////////////////////////////////////
   // core and console

   cpu_sequencer cpu_sequencer_inst (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_load_done  (load_done),
      .i_code_data  (i_code_data),
      .o_fetch_addr (fetch_addr),
      .step         (step_bus.seq)
   );

   cpu_execute cpu_execute_inst (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .step      (step_bus.exe),
      .i_tx_busy (tx_busy),
      .o_tx_stb  (tx_stb),
      .o_tx_byte (tx_byte)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_stb  (tx_stb),
      .i_byte (tx_byte),
      .o_busy (tx_busy),
      .o_tx   (o_uart_tx)
   );

endmodule

// ==== testbench/ice51_chk.sv ====
module ice51_chk_m (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic load_done,
   input  logic code_wr,
   input  logic tx_stb,
   input  logic tx_busy,
   input  logic uart_tx
);
   timeunit 1ns;
   timeprecision 1ns;

   // loader owns the memory only until the last byte is in
   no_write_after_load: assert property (
      @(posedge i_clk) disable iff (!i_nrst) !(code_wr && load_done)
   ) else $error("code write while load_done is high");

   // test programs always poll before a second send
   no_send_while_busy: assert property (
      @(posedge i_clk) disable iff (!i_nrst) !(tx_stb && tx_busy)
   ) else $error("transmit strobe while transmitter busy");

   idle_line_high: assert property (
      @(posedge i_clk) disable iff (!i_nrst) tx_busy || uart_tx
   ) else $error("serial output low while transmitter idle");

endmodule

bind ice51_top ice51_chk_m ice51_chk_inst (
   .i_clk     (i_clk),
   .i_nrst    (i_nrst),
   .load_done (load_done),
   .code_wr   (o_code_wr),
   .tx_stb    (tx_stb),
   .tx_busy   (tx_busy),
   .uart_tx   (o_uart_tx)
);

// ==== testbench/tb_ice51.sv ====
module tb_ice51;
   timeunit 1ns;
   timeprecision 1ns;
   import ice51_pkg::*;

   localparam int CLKS   = 8;    // clocks per serial bit
   localparam int NBYTES = 16;   // program size
   localparam int FRAME  = 10 * CLKS;

   logic                 i_clk, i_nrst, i_uart_rx;
   logic                 o_uart_tx, o_code_wr;
   logic [CODE_AW-1:0]   o_code_addr;
   logic [BYTE_W-1:0]    o_code_data, i_code_data;
   logic [BYTE_W-1:0]    code_mem [0:(1<<CODE_AW)-1];
   logic [BYTE_W-1:0]    prog [0:NBYTES-1];
   integer               seed;

   ice51_top #(.CLKS_PER_BIT(CLKS), .LOAD_BYTES(NBYTES)) ice51_top_inst (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .i_code_data (i_code_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // code memory, read data one cycle behind the address
   always @(posedge i_clk) begin
      if (o_code_wr) code_mem[o_code_addr] <= o_code_data;
      i_code_data <= code_mem[o_code_addr];
   end

   ///////////////////////////////////////////////////////////////////////
   // reporting

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                             input logic [BYTE_W-1:0] act);
      if (act !== exp)
         stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input logic [CODE_AW-1:0] exp,
                             input logic [CODE_AW-1:0] act);
      if (act !== exp)
         stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   ///////////////////////////////////////////////////////////////////////
   // drivers and monitor

   task automatic reset_dut();
      @(posedge i_clk);
      i_nrst    <= 1'b0;
      i_uart_rx <= 1'b1;
      repeat (3) @(posedge i_clk);
      i_nrst <= 1'b1;
      @(posedge i_clk);
   endtask

   task automatic drive_line_bit(input logic b);
      i_uart_rx <= b;
      repeat (CLKS) @(posedge i_clk);
   endtask

   task automatic send_byte(input logic [BYTE_W-1:0] b);
      drive_line_bit(1'b0);
      for (int i = 0; i < BYTE_W; i++) drive_line_bit(b[i]);
      i_uart_rx <= 1'b1;   // stop bit, then idle
   endtask

   // sends one byte and expects exactly one code write for it
   task automatic load_byte(input int idx, input logic [BYTE_W-1:0] b);
      int n;
      n = 0;
      send_byte(b);
      while (!o_code_wr) begin
         if (n == 4 * CLKS) stop_on_error($sformatf("no code write for byte %0d", idx));
         @(posedge i_clk);
         n++;
      end
      check_addr("load address", CODE_AW'(idx), o_code_addr);
      check_byte("load data", b, o_code_data);
      @(posedge i_clk);
      if (o_code_wr) stop_on_error("code write held for more than one cycle");
      repeat (CLKS) @(posedge i_clk);
   endtask

   task automatic load_program();
      for (int i = 0; i < NBYTES; i++) load_byte(i, prog[i]);
   endtask

   task automatic expect_no_write(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(posedge i_clk);
         if (o_code_wr) stop_on_error("code write after the load finished");
      end
   endtask

   task automatic receive_frame(input int tmo, output logic [BYTE_W-1:0] b);
      int n;
      n = 0;
      while (o_uart_tx) begin
         if (n == tmo) stop_on_error("no frame from the transmitter");
         @(posedge i_clk);
         n++;
      end
      repeat (CLKS / 2) @(posedge i_clk);   // middle of start bit
      if (o_uart_tx) stop_on_error("start bit too short");
      for (int i = 0; i < BYTE_W; i++) begin
         repeat (CLKS) @(posedge i_clk);
         b[i] = o_uart_tx;
      end
      repeat (CLKS) @(posedge i_clk);
      if (!o_uart_tx) stop_on_error("stop bit low");
   endtask

   task automatic expect_quiet_line(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(posedge i_clk);
         if (!o_uart_tx) stop_on_error("unexpected extra frame");
      end
   endtask

   task automatic clear_program();
      for (int i = 0; i < NBYTES; i++) prog[i] = 8'h00;   // nop
   endtask

   ///////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic test_reset();
      reset_dut();
      if (o_uart_tx !== 1'b1) stop_on_error("serial output not idle high after reset");
      if (o_code_wr !== 1'b0) stop_on_error("code write active after reset");
   endtask

   task automatic test_load();
      reset_dut();
      prog[0] = OP_SJMP;
      prog[1] = 8'hFE;   // park the core, rest is never run
      for (int i = 2; i < NBYTES; i++) prog[i] = 8'($random(seed));
      load_program();
      // memory is full, one more byte must be dropped
      send_byte(~prog[0]);
      expect_no_write(4 * CLKS);
      for (int i = 0; i < NBYTES; i++) check_byte("stored byte", prog[i], code_mem[i]);
   endtask

   // mov a,#imm / mov dptr,#0201 / movx @dptr,a / sjmp $
   task automatic run_print(input logic [BYTE_W-1:0] a0, input logic [BYTE_W-1:0] k,
                            input bit arith);
      logic [BYTE_W-1:0] got, exp;
      reset_dut();
      clear_program();
      prog[0] = OP_MOVAI;
      prog[1] = a0;
      prog[2] = OP_ADDAI;
      prog[3] = arith ? k : 8'h00;
      prog[4] = arith ? OP_INCA : 8'h00;
      prog[5] = arith ? OP_INCA : 8'h00;
      prog[6] = arith ? OP_DECA : 8'h00;
      prog[7] = OP_MOVDP;
      prog[8] = 8'h02;
      prog[9] = 8'h01;
      prog[10] = OP_MOVXDA;
      prog[11] = OP_SJMP;
      prog[12] = 8'hFE;
      load_program();
      exp = arith ? 8'(a0 + k + 8'd1) : a0;
      receive_frame(4 * FRAME, got);
      check_byte(arith ? "arith result" : "printed byte", exp, got);
      expect_quiet_line(3 * FRAME);
   endtask

   // print, poll the busy flag until the frame is out, dec a and print again
   task automatic test_poll();
      logic [BYTE_W-1:0] got, exp;
      reset_dut();
      clear_program();
      exp = 8'($random(seed));
      prog[0] = OP_MOVAI;
      prog[1] = exp;
      prog[2] = OP_MOVDP;
      prog[3] = 8'h02;
      prog[4] = 8'h01;
      prog[5] = OP_MOVXDA;
      prog[6] = OP_MOVDP;
      prog[7] = 8'h02;
      prog[8] = 8'h00;
      prog[9] = OP_MOVXAD;
      prog[10] = OP_JNZ;
      prog[11] = 8'hFD;   // back to 9 while busy
      prog[12] = OP_DECA;
      prog[13] = OP_JNZ;
      prog[14] = 8'hF3;   // back to 2, the print
      load_program();
      for (int i = 0; i < 3; i++) begin
         receive_frame(4 * FRAME, got);
         check_byte("polled print", exp, got);
         if (o_code_addr < 10'd9 || o_code_addr > 10'd12)
            stop_on_error("core left the poll loop while the transmitter was busy");
         exp = 8'hFF;   // poll leaves a at zero, dec a wraps
      end
   endtask

   initial begin
      i_nrst      = 1'b0;
      i_uart_rx   = 1'b1;
      i_code_data = '0;
      seed        = 90703;
      for (int a = 0; a < (1 << CODE_AW); a++) code_mem[a] = 8'(a ^ (a >> 3) ^ 8'hA5);
      test_reset();
      test_load();
      run_print(8'($random(seed)), 8'h00, 1'b0);
      for (int t = 0; t < 2; t++) run_print(8'($random(seed)), 8'($random(seed)), 1'b1);
      test_poll();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== filelist.f ====
rtl/ice51_pkg.sv
rtl/cpu_step_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/program_loader.sv
rtl/cpu_sequencer.sv
rtl/cpu_execute.sv
rtl/ice51_top.sv
testbench/ice51_chk.sv
testbench/tb_ice51.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run with Verilator, exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ice51 -f filelist.f -o sim_ice51 \
   && ./obj_dir/sim_ice51 \
   || exit 1
